// ==== hw/tcu_pkg.sv ====
//**************************************************************************
// Format codes, meaningful widths and format helpers for the tensor-core
// dot-product stage. Every design module imports this package.
//**************************************************************************
package tcu_pkg;

    // Request format code
    typedef logic [1:0] tcu_fmt_t;

    localparam tcu_fmt_t TCU_FMT_FP16 = 2'd0;
    localparam tcu_fmt_t TCU_FMT_BF16 = 2'd1;
    localparam tcu_fmt_t TCU_FMT_I8   = 2'd2;
    localparam tcu_fmt_t TCU_FMT_U8   = 2'd3;

    // One operand word, split as two halves or four bytes
    typedef logic [31:0] tcu_word_t;

    // Signed significand product, binary point after bit 20
    typedef logic signed [23:0] tcu_prod_t;

    // Sum of two raw exponent fields
    typedef logic [8:0] tcu_exp_t;

    // Accumulator and result value
    typedef logic signed [31:0] tcu_acc_t;

    // FP16 and BF16 take the float lane
    function automatic logic tcu_fmt_is_float(input tcu_fmt_t fmt);
        return (fmt == TCU_FMT_FP16) || (fmt == TCU_FMT_BF16);
    endfunction

    // Only I8 bytes are sign-extended
    function automatic logic tcu_fmt_is_signed(input tcu_fmt_t fmt);
        return fmt == TCU_FMT_I8;
    endfunction

endpackage

// ==== hw/tcu_csa_tree.sv ====
//**************************************************************************
// Carry-save adder tree. Reduces NUM two's complement operands of W bits
// through 3:2 levels and one final carry-propagate add, modulo 2**W.
//**************************************************************************
module tcu_csa_tree #(
    parameter int NUM = 4,
    parameter int W   = 32
) (
    input  logic [NUM-1:0][W-1:0] operands,
    output logic [W-1:0]          sum
);

    logic [W-1:0] cur [NUM];
    logic [W-1:0] nxt [NUM];
    int           cnt;
    int           ncnt;

    // Loop bounds are constant, so every level unrolls at elaboration
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            cur[i] = operands[i];
        end
        cnt = NUM;
        for (int lvl = 0; lvl < NUM; lvl++) begin
            if (cnt > 2) begin
                ncnt = 0;
                for (int i = 0; i < NUM; i++) begin
                    nxt[i] = '0;
                end
                // Full-adder rows: three operands in, sum and shifted carry out
                for (int g = 0; g < NUM / 3; g++) begin
                    if (3 * g + 2 < cnt) begin
                        nxt[ncnt]     = cur[3*g] ^ cur[3*g+1] ^ cur[3*g+2];
                        nxt[ncnt + 1] = ((cur[3*g] & cur[3*g+1]) |
                                         (cur[3*g] & cur[3*g+2]) |
                                         (cur[3*g+1] & cur[3*g+2])) << 1;
                        ncnt = ncnt + 2;
                    end
                end
                // Leftover operands pass to the next level untouched
                for (int i = 0; i < NUM; i++) begin
                    if (i >= (cnt / 3) * 3 && i < cnt) begin
                        nxt[ncnt] = cur[i];
                        ncnt = ncnt + 1;
                    end
                end
                cur = nxt;
                cnt = ncnt;
            end
        end
        sum = (cnt > 1) ? cur[0] + cur[1] : cur[0];
    end

endmodule

// ==== hw/tcu_float_mul.sv ====
//**************************************************************************
// Float lane. Unpacks FP16 or BF16 halves, multiplies 2N significand pairs
// and registers the signed products with their exponent sums.
//**************************************************************************
module tcu_float_mul import tcu_pkg::*; #(
    parameter int N = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  tcu_fmt_t                  fmt,
    input  tcu_word_t [N-1:0]         a_row,
    input  tcu_word_t [N-1:0]         b_col,
    output logic                      flt_valid,
    output tcu_prod_t [2*N-1:0]       flt_prod,
    output tcu_exp_t  [2*N-1:0]       flt_exp
);

    logic                is_float;
    logic                is_bf16;
    tcu_prod_t [2*N-1:0] prod_d;
    tcu_exp_t  [2*N-1:0] exp_d;

    assign is_float = tcu_fmt_is_float(fmt);
    assign is_bf16  = (fmt == TCU_FMT_BF16);

    // Significand on the FP16 binary point and effective exponent of one half
    function automatic void unpack_half(
        input  logic [15:0] h,
        input  logic        bf16,
        output logic [10:0] sig,
        output logic [7:0]  exp,
        output logic        zero
    );
        logic [7:0] e_field;
        logic [9:0] f_field;
        e_field = bf16 ? h[14:7] : {3'b000, h[14:10]};
        // BF16 fraction moves up 3 places to line up with FP16
        f_field = bf16 ? {h[6:0], 3'b000} : h[9:0];
        zero    = (e_field == '0) && (f_field == '0);
        // Hidden bit is clear for zero and subnormal values
        sig     = {e_field != '0, f_field};
        exp     = (e_field == '0) ? 8'd1 : e_field;
    endfunction

    for (genvar i = 0; i < 2 * N; i++) begin : g_half
        localparam int WI  = i / 2;
        localparam int LSB = 16 * (i % 2);

        logic [10:0] sig_a;
        logic [10:0] sig_b;
        logic [7:0]  exp_a;
        logic [7:0]  exp_b;
        logic        zero_a;
        logic        zero_b;
        logic [21:0] mag;
        logic        neg;

        always_comb begin
            unpack_half(a_row[WI][LSB +: 16], is_bf16, sig_a, exp_a, zero_a);
            unpack_half(b_col[WI][LSB +: 16], is_bf16, sig_b, exp_b, zero_b);
        end

        assign mag = sig_a * sig_b;
        assign neg = a_row[WI][LSB + 15] ^ b_col[WI][LSB + 15];

        assign prod_d[i] = neg ? -{2'b00, mag} : {2'b00, mag};
        // Zero products carry exponent 0 so they never win the max search
        assign exp_d[i]  = (zero_a || zero_b) ? '0 : {1'b0, exp_a} + {1'b0, exp_b};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flt_valid <= 1'b0;
        end else begin
            flt_valid <= in_valid && is_float;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && is_float) begin
            flt_prod <= prod_d;
            flt_exp  <= exp_d;
        end
    end

    // A request needs a known format code, or neither lane can claim it
    a_fmt_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> !$isunknown(fmt)
    );

endmodule

// ==== hw/tcu_int_mul.sv ====
//**************************************************************************
// Integer lane. Multiplies 4N byte pairs as I8 or U8, reduces them with
// the C term and registers the total one cycle after the request.
//**************************************************************************
module tcu_int_mul import tcu_pkg::*; #(
    parameter int N = 2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  tcu_fmt_t          fmt,
    input  tcu_word_t [N-1:0] a_row,
    input  tcu_word_t [N-1:0] b_col,
    input  tcu_word_t         c_val,
    output logic              int_valid,
    output tcu_acc_t          int_sum
);

    localparam int NUM_TERMS = 4 * N + 1;

    logic                         is_int;
    logic                         is_signed;
    logic [NUM_TERMS-1:0][31:0]   terms;
    logic [31:0]                  total;

    assign is_int    = !tcu_fmt_is_float(fmt);
    assign is_signed = tcu_fmt_is_signed(fmt);

    // Byte j of word w, each extended to 9 bits so one signed multiply covers both
    for (genvar k = 0; k < 4 * N; k++) begin : g_byte
        localparam int WI  = k / 4;
        localparam int LSB = 8 * (k % 4);

        logic signed [8:0]  a_ext;
        logic signed [8:0]  b_ext;
        logic signed [17:0] prod;

        assign a_ext = {is_signed & a_row[WI][LSB + 7], a_row[WI][LSB +: 8]};
        assign b_ext = {is_signed & b_col[WI][LSB + 7], b_col[WI][LSB +: 8]};
        assign prod  = a_ext * b_ext;

        assign terms[k] = {{14{prod[17]}}, prod};
    end

    // C term rides in the last tree slot
    assign terms[4*N] = c_val;

    tcu_csa_tree #(
        .NUM (NUM_TERMS),
        .W   (32)
    ) u_int_tree (
        .operands (terms),
        .sum      (total)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            int_valid <= 1'b0;
        end else begin
            int_valid <= in_valid && is_int;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && is_int) begin
            int_sum <= total;
        end
    end

endmodule

// ==== hw/tcu_lane_merge.sv ====
//**************************************************************************
// Merge stage. Aligns float products to the largest exponent and sums them,
// or passes the integer total, then registers the selected result.
//**************************************************************************
module tcu_lane_merge import tcu_pkg::*; #(
    parameter int N = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flt_valid,
    input  tcu_prod_t [2*N-1:0] flt_prod,
    input  tcu_exp_t  [2*N-1:0] flt_exp,
    input  logic                int_valid,
    input  tcu_acc_t            int_sum,
    output logic                out_valid,
    output logic                out_is_float,
    output tcu_exp_t            out_exp,
    output tcu_acc_t            out_sig
);

    // Products shifted past this many places vanish entirely
    localparam int MAX_SHIFT = 24;

    tcu_exp_t                max_exp;
    logic [2*N-1:0][31:0]    aligned;
    logic [31:0]             flt_sum;

    // Largest exponent among nonzero products, 0 when all are zero
    always_comb begin
        max_exp = '0;
        for (int i = 0; i < 2 * N; i++) begin
            if (flt_prod[i] != '0 && flt_exp[i] > max_exp) begin
                max_exp = flt_exp[i];
            end
        end
    end

    for (genvar i = 0; i < 2 * N; i++) begin : g_align
        tcu_exp_t diff;
        tcu_acc_t wide;
        tcu_acc_t shifted;

        // Zero products may wrap here, but a zero stays zero after any shift
        assign diff = max_exp - flt_exp[i];

        assign wide    = {{8{flt_prod[i][23]}}, flt_prod[i]};
        assign shifted = wide >>> diff[4:0];

        assign aligned[i] = (diff >= MAX_SHIFT) ? '0 : shifted;
    end

    tcu_csa_tree #(
        .NUM (2 * N),
        .W   (32)
    ) u_flt_tree (
        .operands (aligned),
        .sum      (flt_sum)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= flt_valid || int_valid;
        end
    end

    // At most one lane is valid, so the float branch can take priority
    always_ff @(posedge clk) begin
        if (flt_valid) begin
            out_is_float <= 1'b1;
            out_exp      <= max_exp;
            out_sig      <= flt_sum;
        end else if (int_valid) begin
            out_is_float <= 1'b0;
            out_exp      <= '0;
            out_sig      <= int_sum;
        end
    end

    // The two lanes decode disjoint formats of the same request stream
    a_one_lane: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(flt_valid && int_valid)
    );

endmodule

// ==== hw/tcu_dot_top.sv ====
//**************************************************************************
// Top level of the dot-product stage. Feeds each request to both lanes
// and merges their results; out_valid follows in_valid by two cycles.
//**************************************************************************
module tcu_dot_top import tcu_pkg::*; #(
    parameter int N = 2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  tcu_fmt_t          fmt,
    input  tcu_word_t [N-1:0] a_row,
    input  tcu_word_t [N-1:0] b_col,
    input  tcu_word_t         c_val,
    output logic              out_valid,
    output logic              out_is_float,
    output tcu_exp_t          out_exp,
    output tcu_acc_t          out_sig
);

    logic                flt_valid;
    tcu_prod_t [2*N-1:0] flt_prod;
    tcu_exp_t  [2*N-1:0] flt_exp;
    logic                int_valid;
    tcu_acc_t            int_sum;

    tcu_float_mul #(
        .N (N)
    ) u_float_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .fmt       (fmt),
        .a_row     (a_row),
        .b_col     (b_col),
        .flt_valid (flt_valid),
        .flt_prod  (flt_prod),
        .flt_exp   (flt_exp)
    );

    tcu_int_mul #(
        .N (N)
    ) u_int_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .fmt       (fmt),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .int_valid (int_valid),
        .int_sum   (int_sum)
    );

    tcu_lane_merge #(
        .N (N)
    ) u_lane_merge (
        .clk          (clk),
        .arst_n       (arst_n),
        .flt_valid    (flt_valid),
        .flt_prod     (flt_prod),
        .flt_exp      (flt_exp),
        .int_valid    (int_valid),
        .int_sum      (int_sum),
        .out_valid    (out_valid),
        .out_is_float (out_is_float),
        .out_exp      (out_exp),
        .out_sig      (out_sig)
    );

endmodule

// ==== tests/tcu_dot_tb.sv ====
//**************************************************************************
// Testbench for the dot-product stage. Applies a table of directed and
// LFSR rows back to back and checks every result and its latency.
//**************************************************************************
module tcu_dot_tb import tcu_pkg::*; ();

    localparam int N            = 2;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 32;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              in_valid;
    tcu_fmt_t          fmt;
    logic [N-1:0][31:0] a_row;
    logic [N-1:0][31:0] b_col;
    logic [31:0]       c_val;
    logic              out_valid;
    logic              out_is_float;
    logic [8:0]        out_exp;
    logic [31:0]       out_sig;

    // Stimulus table, one entry per row in every queue
    string             row_name [$];
    logic [1:0]        row_fmt [$];
    logic [N*32-1:0]   row_a [$];
    logic [N*32-1:0]   row_b [$];
    logic [31:0]       row_c [$];
    logic              row_float [$];
    logic [8:0]        row_exp [$];
    logic [31:0]       row_sig [$];

    // Requests in flight and the cycle their result is due
    int                pend_idx [$];
    int                pend_due [$];

    int                cycle = 0;
    logic              table_ready = 1'b0;
    logic [31:0]       lfsr = 32'hc070d070;

    tcu_dot_top #(
        .N (N)
    ) u_tcu_dot_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .fmt          (fmt),
        .a_row        (a_row),
        .b_col        (b_col),
        .c_val        (c_val),
        .out_valid    (out_valid),
        .out_is_float (out_is_float),
        .out_exp      (out_exp),
        .out_sig      (out_sig)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Significand on the FP16 binary point, effective exponent, zero flag
    function automatic void split_half(input logic [15:0] h, input logic bf,
                                       output int sig, output int e, output logic zero);
        int ef;
        int ff;
        if (bf) begin
            ef = int'(h[14:7]);
            ff = int'(h[6:0]) * 8;
        end else begin
            ef = int'(h[14:10]);
            ff = int'(h[9:0]);
        end
        zero = (ef == 0) && (ff == 0);
        sig  = (ef == 0) ? ff : 1024 + ff;
        e    = (ef == 0) ? 1 : ef;
    endfunction

    function automatic void ref_model(input logic [1:0] f, input logic [N*32-1:0] a,
                                      input logic [N*32-1:0] b, input logic [31:0] c,
                                      output logic is_flt, output logic [8:0] e_out,
                                      output logic [31:0] s_out);
        int   sa;
        int   sb;
        int   ea;
        int   eb;
        int   mx;
        int   d;
        int   acc;
        int   av;
        int   bv;
        logic za;
        logic zb;
        logic bf;
        int   pv [2*N];
        int   pe [2*N];
        logic pz [2*N];
        is_flt = (f == TCU_FMT_FP16) || (f == TCU_FMT_BF16);
        bf     = (f == TCU_FMT_BF16);
        acc    = 0;
        mx     = 0;
        if (is_flt) begin
            for (int i = 0; i < 2 * N; i++) begin
                split_half(a[16*i +: 16], bf, sa, ea, za);
                split_half(b[16*i +: 16], bf, sb, eb, zb);
                pz[i] = za || zb;
                pv[i] = (a[16*i+15] ^ b[16*i+15]) ? -(sa * sb) : sa * sb;
                pe[i] = pz[i] ? 0 : ea + eb;
                if (!pz[i] && pe[i] > mx) begin
                    mx = pe[i];
                end
            end
            for (int i = 0; i < 2 * N; i++) begin
                d = mx - pe[i];
                if (!pz[i] && d < 24) begin
                    acc = acc + (pv[i] >>> d);
                end
            end
            e_out = 9'(mx);
        end else begin
            for (int k = 0; k < 4 * N; k++) begin
                av = int'(a[8*k +: 8]);
                bv = int'(b[8*k +: 8]);
                if (f == TCU_FMT_I8) begin
                    av = (av > 127) ? av - 256 : av;
                    bv = (bv > 127) ? bv - 256 : bv;
                end
                acc = acc + av * bv;
            end
            acc   = acc + int'(c);
            e_out = '0;
        end
        s_out = acc;
    endfunction

    task automatic add_row(input string name, input logic [1:0] f, input logic [N*32-1:0] a,
                           input logic [N*32-1:0] b, input logic [31:0] c, input logic flt,
                           input logic [8:0] e, input logic [31:0] s);
        row_name.push_back(name);
        row_fmt.push_back(f);
        row_a.push_back(a);
        row_b.push_back(b);
        row_c.push_back(c);
        row_float.push_back(flt);
        row_exp.push_back(e);
        row_sig.push_back(s);
    endtask

    task automatic apply_row(input int i);
        in_valid = 1'b1;
        fmt      = row_fmt[i];
        a_row    = row_a[i];
        b_col    = row_b[i];
        c_val    = row_c[i];
        pend_idx.push_back(i);
        pend_due.push_back(cycle + 2);
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        int idx;
        int due;
        if (out_valid === 1'b1) begin
            if (pend_idx.size() == 0) begin
                fail_run("out_valid was raised with no request in flight");
            end else begin
                idx = pend_idx.pop_front();
                due = pend_due.pop_front();
                check_value($sformatf("%s.cycle", row_name[idx]), 32'(due), 32'(cycle));
                check_value($sformatf("%s.is_float", row_name[idx]),
                            32'(row_float[idx]), 32'(out_is_float));
                check_value($sformatf("%s.exp", row_name[idx]),
                            32'(row_exp[idx]), 32'(out_exp));
                check_value($sformatf("%s.sig", row_name[idx]), row_sig[idx], out_sig);
            end
        end else if (out_valid !== 1'b0) begin
            fail_run("out_valid is unknown");
        end
    end

    initial begin
        wait (table_ready);
        repeat (row_name.size() + RESET_CYCLES + 20) @(posedge clk);
        fail_run($sformatf("Timeout with %0d results still missing", pend_idx.size()));
    end

    initial begin
        logic [63:0]     bits;
        logic [1:0]      rf;
        logic [N*32-1:0] ra;
        logic [N*32-1:0] rb;
        logic            rflt;
        logic [8:0]      re;
        logic [31:0]     rs;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        fmt      = TCU_FMT_FP16;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;

        // Float and integer rows alternate to mix the two lanes back to back
        add_row("fp16_align", TCU_FMT_FP16, 64'h0000_3800_4000_3C00,
                64'h4400_3E00_BC00_3C00, 32'd0, 1'b1, 9'd31, -32'sd131072);
        add_row("i8_mixed", TCU_FMT_I8, 64'h0110_C080_807F_FF02,
                64'hFFF0_407F_8002_FF03, -32'sd1000, 1'b0, 9'd0, -32'sd4964);
        add_row("bf16_shift", TCU_FMT_BF16, 64'h4000_3F81_BFC0_3FC0,
                64'hBF80_3F80_3F80_3F80, 32'd0, 1'b1, 9'd255, -32'sd520192);
        add_row("u8_mixed", TCU_FMT_U8, 64'h0110_C080_807F_FF02,
                64'hFFF0_407F_8002_FF03, -32'sd1000, 1'b0, 9'd0, 32'd113308);
        // Shift of 23 keeps a negative product at -1, a shift of 24 drops it
        add_row("fp16_drop", TCU_FMT_FP16, 64'hD400_D800_0200_7800,
                64'h3C00_3C00_0400_7800, 32'd0, 1'b1, 9'd60, 32'd1048575);
        add_row("i8_wrap", TCU_FMT_I8, 64'h8080_8080_8080_8080,
                64'h8080_8080_8080_8080, 32'h7FFF_FFFF, 1'b0, 9'd0, 32'h8001_FFFF);
        add_row("fp16_subnormal", TCU_FMT_FP16, 64'h8000_0000_8001_03FF,
                64'h3C00_0000_0400_3C00, 32'd0, 1'b1, 9'd16, 32'd1047551);
        add_row("u8_max", TCU_FMT_U8, 64'hFFFF_FFFF_FFFF_FFFF,
                64'hFFFF_FFFF_FFFF_FFFF, 32'd0, 1'b0, 9'd0, 32'd520200);
        add_row("bf16_cancel", TCU_FMT_BF16, 64'h0000_0000_C040_4040,
                64'h0000_0000_4040_4040, 32'd0, 1'b1, 9'd256, 32'd0);
        add_row("fp16_zero", TCU_FMT_FP16, 64'h0000_0000_0000_0000,
                64'h3C00_3C00_3C00_3C00, 32'd0, 1'b1, 9'd0, 32'd0);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            take_bits(2, bits);
            rf = bits[1:0];
            take_bits(N * 32, bits);
            ra = bits[N*32-1:0];
            take_bits(N * 32, bits);
            rb = bits[N*32-1:0];
            take_bits(32, bits);
            ref_model(rf, ra, rb, bits[31:0], rflt, re, rs);
            add_row($sformatf("random_%0d", r), rf, ra, rb, bits[31:0], rflt, re, rs);
        end
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge clk);

        for (int i = 0; i < row_name.size(); i++) begin
            @(posedge clk);
            #1;
            apply_row(i);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;

        while (pend_idx.size() != 0) begin
            @(posedge clk);
        end
        // A few quiet cycles catch any stray out_valid
        repeat (3) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tcu_dot_top.f ====
hw/tcu_pkg.sv
hw/tcu_csa_tree.sv
hw/tcu_float_mul.sv
hw/tcu_int_mul.sv
hw/tcu_lane_merge.sv
hw/tcu_dot_top.sv
tests/tcu_dot_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the dot-product stage

VERILATOR  ?= verilator
TOP        ?= tcu_dot_tb
RTL_TOP    ?= tcu_dot_top
FILELIST   ?= tcu_dot_top.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the testbench printed its pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		hw/tcu_pkg.sv hw/tcu_csa_tree.sv hw/tcu_float_mul.sv \
		hw/tcu_int_mul.sv hw/tcu_lane_merge.sv hw/tcu_dot_top.sv

clean:
	rm -rf $(BUILD_DIR)
